// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    // ====================
    // architectural widths
    // ====================
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int CSR_IDX_W = 2;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // machine-mode csr slots kept by this core
    typedef enum logic [CSR_IDX_W-1:0] {
        CSR_MSTATUS = 2'd0,
        CSR_MTVEC   = 2'd1,
        CSR_MEPC    = 2'd2,
        CSR_MCAUSE  = 2'd3
    } csr_idx_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_BYTE = 2'd1,
        MEM_HALF = 2'd2,
        MEM_WORD = 2'd3
    } mem_size_t;

    // pc step for link values
    localparam word_t PC_STEP = word_t'(4);

endpackage

// File: src/exu_ctrl_pkg.sv
package exu_ctrl_pkg;

    import rv_isa_pkg::*;

    localparam int ALU_OP_W = 4;

    // ====================
    // control encodings
    // ====================
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_OR     = 4'd4,
        ALU_AND    = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    typedef enum logic {
        SRC_A_RS1 = 1'b0,
        SRC_A_PC  = 1'b1
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'd0,
        SRC_B_IMM  = 2'd1,
        SRC_B_FOUR = 2'd2,
        SRC_B_CSR  = 2'd3
    } src_b_t;

    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_ALWAYS = 3'd1,
        BR_EQ     = 3'd2,
        BR_NE     = 3'd3,
        BR_GE     = 3'd4,
        BR_LT     = 3'd5
    } br_cond_t;

    typedef enum logic [1:0] {
        TGT_PC  = 2'd0,
        TGT_RS1 = 2'd1,
        TGT_CSR = 2'd2
    } tgt_base_t;

    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_RW    = 2'd1,
        CSR_OP_RS    = 2'd2,
        CSR_OP_ECALL = 2'd3
    } csr_op_t;

    // ====================
    // stage payloads
    // ====================
    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     csr_data;
        reg_idx_t  rd;
        csr_idx_t  csr_rd;
        alu_op_t   alu_op;
        src_a_t    src_a;
        src_b_t    src_b;
        br_cond_t  br_cond;
        tgt_base_t tgt_base;
        csr_op_t   csr_op;
        logic      write_gpr;
        logic      write_csr;
        logic      mem_to_reg;
        logic      mem_write;
        mem_size_t mem_size;
        logic      mem_unsigned;
        logic      halt;
    } exu_issue_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_out;
        word_t     csr_out;
        word_t     store_data;
        word_t     target;
        reg_idx_t  rd;
        csr_idx_t  csr_rd;
        logic      write_gpr;
        logic      write_csr;
        logic      mem_to_reg;
        logic      mem_write;
        mem_size_t mem_size;
        logic      mem_unsigned;
        logic      halt;
        logic      redirect;
    } exu_result_t;

endpackage

// File: src/exu_stage_reg.sv
module exu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  logic     bubble,
    input  payload_t d,
    output logic     valid,
    output payload_t q
);

    // valid marks a live instruction in q
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (bubble) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end
    end

    // payload only moves on a real load
    always_ff @(posedge clk) begin
        if (load && !bubble) begin
            q <= d;
        end
    end

endmodule

// File: src/exu_operand_mux.sv
module exu_operand_mux (
    input  rv_isa_pkg::word_t    rs1_data,
    input  rv_isa_pkg::word_t    rs2_data,
    input  rv_isa_pkg::word_t    csr_data,
    input  logic                 fwd_rs1_sel,
    input  logic                 fwd_rs2_sel,
    input  logic                 fwd_csr_sel,
    input  rv_isa_pkg::word_t    fwd_rs1_data,
    input  rv_isa_pkg::word_t    fwd_rs2_data,
    input  rv_isa_pkg::word_t    fwd_csr_data,
    input  rv_isa_pkg::word_t    pc,
    input  rv_isa_pkg::word_t    imm,
    input  exu_ctrl_pkg::src_a_t src_a,
    input  exu_ctrl_pkg::src_b_t src_b,
    output rv_isa_pkg::word_t    rs1_eff,
    output rv_isa_pkg::word_t    rs2_eff,
    output rv_isa_pkg::word_t    csr_eff,
    output rv_isa_pkg::word_t    op_a,
    output rv_isa_pkg::word_t    op_b
);

    import rv_isa_pkg::*;
    import exu_ctrl_pkg::*;

    // ====================
    // forwarding
    // ====================
    // newer value from mem/wb wins over the register file read
    assign rs1_eff = fwd_rs1_sel ? fwd_rs1_data : rs1_data;
    assign rs2_eff = fwd_rs2_sel ? fwd_rs2_data : rs2_data;
    assign csr_eff = fwd_csr_sel ? fwd_csr_data : csr_data;

    // ====================
    // alu operands
    // ====================
    assign op_a = (src_a == SRC_A_PC) ? pc : rs1_eff;

    always_comb begin
        case (src_b)
            SRC_B_RS2:  op_b = rs2_eff;
            SRC_B_IMM:  op_b = imm;
            // link value for jal/jalr
            SRC_B_FOUR: op_b = PC_STEP;
            SRC_B_CSR:  op_b = csr_eff;
            default:    op_b = rs2_eff;
        endcase
    end

endmodule

// File: src/exu_alu.sv
module exu_alu (
    input  rv_isa_pkg::word_t     op_a,
    input  rv_isa_pkg::word_t     op_b,
    input  exu_ctrl_pkg::alu_op_t alu_op,
    input  exu_ctrl_pkg::csr_op_t csr_op,
    input  rv_isa_pkg::word_t     rs1_eff,
    input  rv_isa_pkg::word_t     csr_eff,
    input  rv_isa_pkg::word_t     pc,
    output rv_isa_pkg::word_t     alu_out,
    output rv_isa_pkg::word_t     csr_out,
    output logic                  less,
    output logic                  zero
);

    import rv_isa_pkg::*;
    import exu_ctrl_pkg::*;

    logic       less_s;
    logic       less_u;
    logic [4:0] shamt;

    // ====================
    // compare
    // ====================
    assign less_s = $signed(op_a) < $signed(op_b);
    assign less_u = op_a < op_b;
    assign zero   = (op_a == op_b);

    // branches pick signed or unsigned through the alu op
    assign less = (alu_op == ALU_SLTU) ? less_u : less_s;

    assign shamt = op_b[4:0];

    // ====================
    // result
    // ====================
    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLT:    alu_out = word_t'(less_s);
            ALU_SLTU:   alu_out = word_t'(less_u);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> shamt);
            // lui and csr reads go straight through
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // ====================
    // csr write value
    // ====================
    always_comb begin
        case (csr_op)
            CSR_OP_RW:    csr_out = rs1_eff;
            CSR_OP_RS:    csr_out = csr_eff | rs1_eff;
            // trapping pc goes to mepc
            CSR_OP_ECALL: csr_out = pc;
            default:      csr_out = csr_eff;
        endcase
    end

endmodule

// File: src/exu_branch.sv
module exu_branch (
    input  exu_ctrl_pkg::br_cond_t  br_cond,
    input  exu_ctrl_pkg::tgt_base_t tgt_base,
    input  rv_isa_pkg::word_t       pc,
    input  rv_isa_pkg::word_t       imm,
    input  rv_isa_pkg::word_t       rs1_eff,
    input  rv_isa_pkg::word_t       csr_eff,
    input  logic                    less,
    input  logic                    zero,
    output logic                    taken,
    output rv_isa_pkg::word_t       target
);

    import rv_isa_pkg::*;
    import exu_ctrl_pkg::*;

    word_t pc_rel;
    word_t rs1_rel;

    // ====================
    // condition
    // ====================
    always_comb begin
        case (br_cond)
            BR_NONE:   taken = 1'b0;
            BR_ALWAYS: taken = 1'b1;
            BR_EQ:     taken = zero;
            BR_NE:     taken = !zero;
            BR_GE:     taken = !less;
            BR_LT:     taken = less;
            default:   taken = 1'b0;
        endcase
    end

    // ====================
    // target
    // ====================
    assign pc_rel  = pc + imm;
    // jalr drops bit 0
    assign rs1_rel = (rs1_eff + imm) & ~word_t'(1);

    always_comb begin
        case (tgt_base)
            TGT_PC:  target = pc_rel;
            TGT_RS1: target = rs1_rel;
            // mtvec on ecall, mepc on mret, no offset
            TGT_CSR: target = csr_eff;
            default: target = pc_rel;
        endcase
    end

endmodule

// File: src/exu_control.sv
module exu_control (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  logic stage_valid,
    input  logic taken,
    input  logic halt_committing,
    output logic issue_load,
    output logic issue_bubble,
    output logic result_load,
    output logic result_bubble,
    output logic halted
);

    logic wrong_path;
    logic halt_block;

    // ====================
    // squash decisions
    // ====================
    // a taken branch in the stage kills the issue behind it
    assign wrong_path = stage_valid && taken;

    // committing halt already blocks the next edge
    assign halt_block = halted || halt_committing;

    // issue register
    assign issue_load   = issue_valid && !wrong_path && !halt_block;
    // no load means the slot empties, nothing is held
    assign issue_bubble = !issue_load;

    // result register follows the stage unless a halt blocks it
    assign result_load   = stage_valid && !halt_block;
    assign result_bubble = !result_load;

    // ====================
    // halt latch
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_committing) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: src/exu_top.sv
module exu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  rv_isa_pkg::word_t       pc,
    input  rv_isa_pkg::word_t       imm,
    input  rv_isa_pkg::word_t       rs1_data,
    input  rv_isa_pkg::word_t       rs2_data,
    input  rv_isa_pkg::word_t       csr_data,
    input  rv_isa_pkg::reg_idx_t    rd,
    input  rv_isa_pkg::csr_idx_t    csr_rd,
    input  exu_ctrl_pkg::alu_op_t   alu_op,
    input  exu_ctrl_pkg::src_a_t    src_a,
    input  exu_ctrl_pkg::src_b_t    src_b,
    input  exu_ctrl_pkg::br_cond_t  br_cond,
    input  exu_ctrl_pkg::tgt_base_t tgt_base,
    input  exu_ctrl_pkg::csr_op_t   csr_op,
    input  logic                    write_gpr,
    input  logic                    write_csr,
    input  logic                    mem_to_reg,
    input  logic                    mem_write,
    input  rv_isa_pkg::mem_size_t   mem_size,
    input  logic                    mem_unsigned,
    input  logic                    halt,
    // forwarding for the instruction in the stage
    input  logic                    fwd_rs1_sel,
    input  logic                    fwd_rs2_sel,
    input  logic                    fwd_csr_sel,
    input  rv_isa_pkg::word_t       fwd_rs1_data,
    input  rv_isa_pkg::word_t       fwd_rs2_data,
    input  rv_isa_pkg::word_t       fwd_csr_data,
    output logic                    commit,
    output rv_isa_pkg::word_t       res_pc,
    output rv_isa_pkg::word_t       alu_out,
    output rv_isa_pkg::word_t       csr_out,
    output rv_isa_pkg::word_t       store_data,
    output rv_isa_pkg::reg_idx_t    res_rd,
    output rv_isa_pkg::csr_idx_t    res_csr_rd,
    output logic                    res_write_gpr,
    output logic                    res_write_csr,
    output logic                    res_mem_to_reg,
    output logic                    res_mem_write,
    output rv_isa_pkg::mem_size_t   res_mem_size,
    output logic                    res_mem_unsigned,
    output logic                    res_halt,
    output logic                    redirect,
    output rv_isa_pkg::word_t       target,
    output logic                    halted
);

    import rv_isa_pkg::*;
    import exu_ctrl_pkg::*;

    exu_issue_t  issue_d;
    exu_issue_t  issue_q;
    exu_result_t result_d;
    exu_result_t result_q;

    logic  issue_load;
    logic  issue_bubble;
    logic  result_load;
    logic  result_bubble;
    logic  stage_valid;
    logic  halt_committing;

    word_t rs1_eff;
    word_t rs2_eff;
    word_t csr_eff;
    word_t op_a;
    word_t op_b;
    word_t ex_alu_out;
    word_t ex_csr_out;
    word_t ex_target;
    logic  less;
    logic  zero;
    logic  taken;

    // ====================
    // issue side
    // ====================
    always_comb begin
        issue_d.pc           = pc;
        issue_d.imm          = imm;
        issue_d.rs1_data     = rs1_data;
        issue_d.rs2_data     = rs2_data;
        issue_d.csr_data     = csr_data;
        issue_d.rd           = rd;
        issue_d.csr_rd       = csr_rd;
        issue_d.alu_op       = alu_op;
        issue_d.src_a        = src_a;
        issue_d.src_b        = src_b;
        issue_d.br_cond      = br_cond;
        issue_d.tgt_base     = tgt_base;
        issue_d.csr_op       = csr_op;
        issue_d.write_gpr    = write_gpr;
        issue_d.write_csr    = write_csr;
        issue_d.mem_to_reg   = mem_to_reg;
        issue_d.mem_write    = mem_write;
        issue_d.mem_size     = mem_size;
        issue_d.mem_unsigned = mem_unsigned;
        issue_d.halt         = halt;
    end

    exu_control u_control (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .stage_valid     (stage_valid),
        .taken           (taken),
        .halt_committing (halt_committing),
        .issue_load      (issue_load),
        .issue_bubble    (issue_bubble),
        .result_load     (result_load),
        .result_bubble   (result_bubble),
        .halted          (halted)
    );

    exu_stage_reg #(.payload_t(exu_issue_t)) u_issue_reg (
        .clk    (clk),
        .reset  (reset),
        .load   (issue_load),
        .bubble (issue_bubble),
        .d      (issue_d),
        .valid  (stage_valid),
        .q      (issue_q)
    );

    // ====================
    // datapath
    // ====================
    exu_operand_mux u_operand_mux (
        .rs1_data     (issue_q.rs1_data),
        .rs2_data     (issue_q.rs2_data),
        .csr_data     (issue_q.csr_data),
        .fwd_rs1_sel  (fwd_rs1_sel),
        .fwd_rs2_sel  (fwd_rs2_sel),
        .fwd_csr_sel  (fwd_csr_sel),
        .fwd_rs1_data (fwd_rs1_data),
        .fwd_rs2_data (fwd_rs2_data),
        .fwd_csr_data (fwd_csr_data),
        .pc           (issue_q.pc),
        .imm          (issue_q.imm),
        .src_a        (issue_q.src_a),
        .src_b        (issue_q.src_b),
        .rs1_eff      (rs1_eff),
        .rs2_eff      (rs2_eff),
        .csr_eff      (csr_eff),
        .op_a         (op_a),
        .op_b         (op_b)
    );

    exu_alu u_alu (
        .op_a    (op_a),
        .op_b    (op_b),
        .alu_op  (issue_q.alu_op),
        .csr_op  (issue_q.csr_op),
        .rs1_eff (rs1_eff),
        .csr_eff (csr_eff),
        .pc      (issue_q.pc),
        .alu_out (ex_alu_out),
        .csr_out (ex_csr_out),
        .less    (less),
        .zero    (zero)
    );

    exu_branch u_branch (
        .br_cond  (issue_q.br_cond),
        .tgt_base (issue_q.tgt_base),
        .pc       (issue_q.pc),
        .imm      (issue_q.imm),
        .rs1_eff  (rs1_eff),
        .csr_eff  (csr_eff),
        .less     (less),
        .zero     (zero),
        .taken    (taken),
        .target   (ex_target)
    );

    // ====================
    // result side
    // ====================
    always_comb begin
        result_d.pc           = issue_q.pc;
        result_d.alu_out      = ex_alu_out;
        result_d.csr_out      = ex_csr_out;
        result_d.store_data   = rs2_eff;
        result_d.target       = ex_target;
        result_d.rd           = issue_q.rd;
        result_d.csr_rd       = issue_q.csr_rd;
        result_d.write_gpr    = issue_q.write_gpr;
        result_d.write_csr    = issue_q.write_csr;
        result_d.mem_to_reg   = issue_q.mem_to_reg;
        result_d.mem_write    = issue_q.mem_write;
        result_d.mem_size     = issue_q.mem_size;
        result_d.mem_unsigned = issue_q.mem_unsigned;
        result_d.halt         = issue_q.halt;
        result_d.redirect     = taken;
    end

    exu_stage_reg #(.payload_t(exu_result_t)) u_result_reg (
        .clk    (clk),
        .reset  (reset),
        .load   (result_load),
        .bubble (result_bubble),
        .d      (result_d),
        .valid  (commit),
        .q      (result_q)
    );

    assign halt_committing = commit && result_q.halt;

    // redirect pulses with commit only
    assign redirect = commit && result_q.redirect;

    assign res_pc           = result_q.pc;
    assign alu_out          = result_q.alu_out;
    assign csr_out          = result_q.csr_out;
    assign store_data       = result_q.store_data;
    assign target           = result_q.target;
    assign res_rd           = result_q.rd;
    assign res_csr_rd       = result_q.csr_rd;
    assign res_write_gpr    = result_q.write_gpr;
    assign res_write_csr    = result_q.write_csr;
    assign res_mem_to_reg   = result_q.mem_to_reg;
    assign res_mem_write    = result_q.mem_write;
    assign res_mem_size     = result_q.mem_size;
    assign res_mem_unsigned = result_q.mem_unsigned;
    assign res_halt         = result_q.halt;

endmodule

// File: verification/exu_tb.sv
module exu_tb;

    import rv_isa_pkg::*;
    import exu_ctrl_pkg::*;

    localparam int ROW_FIELDS    = 26;
    localparam int HEADER_LINES  = 2;
    localparam int MAX_ROWS      = 1000;
    localparam int LATENCY       = 2;
    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 20;

    // one queued expectation per trace row
    typedef struct packed {
        int         row;
        int         cyc;
        word_t      pc;
        reg_idx_t   rd;
        csr_idx_t   csr_rd;
        logic [7:0] flags;
        logic       commit;
        word_t      alu_out;
        word_t      csr_out;
        word_t      store_data;
        logic       redirect;
        word_t      target;
        logic       halted;
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      issue_valid;
    word_t     pc;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     csr_data;
    reg_idx_t  rd;
    csr_idx_t  csr_rd;
    alu_op_t   alu_op;
    src_a_t    src_a;
    src_b_t    src_b;
    br_cond_t  br_cond;
    tgt_base_t tgt_base;
    csr_op_t   csr_op;
    logic      write_gpr;
    logic      write_csr;
    logic      mem_to_reg;
    logic      mem_write;
    mem_size_t mem_size;
    logic      mem_unsigned;
    logic      halt;
    logic      fwd_rs1_sel;
    logic      fwd_rs2_sel;
    logic      fwd_csr_sel;
    word_t     fwd_rs1_data;
    word_t     fwd_rs2_data;
    word_t     fwd_csr_data;
    logic      commit;
    word_t     res_pc;
    word_t     alu_out;
    word_t     csr_out;
    word_t     store_data;
    reg_idx_t  res_rd;
    csr_idx_t  res_csr_rd;
    logic      res_write_gpr;
    logic      res_write_csr;
    logic      res_mem_to_reg;
    logic      res_mem_write;
    mem_size_t res_mem_size;
    logic      res_mem_unsigned;
    logic      res_halt;
    logic      redirect;
    word_t     target;
    logic      halted;

    // fields of the current trace row
    logic [31:0] t_v, t_pc, t_imm, t_rs1, t_rs2, t_csr, t_rd, t_crd, t_alu;
    logic [31:0] t_sa, t_sb, t_br, t_tb, t_cop, t_flg;
    logic [31:0] t_fsel, t_f1, t_f2, t_fc;
    logic [31:0] t_ec, t_ealu, t_ecsr, t_est, t_erd, t_etgt, t_eh;

    expect_t exp_q[$];
    int      fd;
    int      code;
    int      cyc;
    int      row_cnt;
    int      wait_cnt;
    int      cur_row;
    string   hdr;
    logic    trace_done;

    always #50 clk = ~clk;

    exu_top dut (.*);

    // ====================
    // checks
    // ====================
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    task automatic check_csr_idx(input string name, input csr_idx_t got, input csr_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    // compare the row issued LATENCY cycles ago when one is due
    task automatic check_due();
        expect_t e;
        if (exp_q.size() != 0 && exp_q[0].cyc + LATENCY == cyc) begin
            e = exp_q.pop_front();
            cur_row = e.row;
            check_flag("halted", halted, e.halted);
            check_flag("commit", commit, e.commit);
            if (e.commit) begin
                check_word("res_pc", res_pc, e.pc);
                check_word("alu_out", alu_out, e.alu_out);
                check_word("csr_out", csr_out, e.csr_out);
                check_word("store_data", store_data, e.store_data);
                check_flag("redirect", redirect, e.redirect);
                if (e.redirect) begin
                    check_word("target", target, e.target);
                end
                // pass-through fields come back as issued
                check_idx("res_rd", res_rd, e.rd);
                check_csr_idx("res_csr_rd", res_csr_rd, e.csr_rd);
                check_flag("res_write_gpr", res_write_gpr, e.flags[7]);
                check_flag("res_write_csr", res_write_csr, e.flags[6]);
                check_flag("res_mem_to_reg", res_mem_to_reg, e.flags[5]);
                check_flag("res_mem_write", res_mem_write, e.flags[4]);
                check_size("res_mem_size", res_mem_size, mem_size_t'(e.flags[3:2]));
                check_flag("res_mem_unsigned", res_mem_unsigned, e.flags[1]);
                check_flag("res_halt", res_halt, e.flags[0]);
            end else begin
                check_flag("redirect", redirect, 1'b0);
            end
        end
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic init_inputs();
        reset        <= 1'b1;
        issue_valid  <= 1'b0;
        pc           <= '0;
        imm          <= '0;
        rs1_data     <= '0;
        rs2_data     <= '0;
        csr_data     <= '0;
        rd           <= '0;
        csr_rd       <= CSR_MSTATUS;
        alu_op       <= ALU_ADD;
        src_a        <= SRC_A_RS1;
        src_b        <= SRC_B_RS2;
        br_cond      <= BR_NONE;
        tgt_base     <= TGT_PC;
        csr_op       <= CSR_OP_NONE;
        write_gpr    <= 1'b0;
        write_csr    <= 1'b0;
        mem_to_reg   <= 1'b0;
        mem_write    <= 1'b0;
        mem_size     <= MEM_NONE;
        mem_unsigned <= 1'b0;
        halt         <= 1'b0;
        fwd_rs1_sel  <= 1'b0;
        fwd_rs2_sel  <= 1'b0;
        fwd_csr_sel  <= 1'b0;
        fwd_rs1_data <= '0;
        fwd_rs2_data <= '0;
        fwd_csr_data <= '0;
    endtask

    task automatic drive_row();
        issue_valid  <= t_v[0];
        pc           <= t_pc;
        imm          <= t_imm;
        rs1_data     <= t_rs1;
        rs2_data     <= t_rs2;
        csr_data     <= t_csr;
        rd           <= t_rd[4:0];
        csr_rd       <= csr_idx_t'(t_crd[1:0]);
        alu_op       <= alu_op_t'(t_alu[3:0]);
        src_a        <= src_a_t'(t_sa[0]);
        src_b        <= src_b_t'(t_sb[1:0]);
        br_cond      <= br_cond_t'(t_br[2:0]);
        tgt_base     <= tgt_base_t'(t_tb[1:0]);
        csr_op       <= csr_op_t'(t_cop[1:0]);
        write_gpr    <= t_flg[7];
        write_csr    <= t_flg[6];
        mem_to_reg   <= t_flg[5];
        mem_write    <= t_flg[4];
        mem_size     <= mem_size_t'(t_flg[3:2]);
        mem_unsigned <= t_flg[1];
        halt         <= t_flg[0];
        // forwarding belongs to the previous row
        fwd_rs1_sel  <= t_fsel[0];
        fwd_rs2_sel  <= t_fsel[1];
        fwd_csr_sel  <= t_fsel[2];
        fwd_rs1_data <= t_f1;
        fwd_rs2_data <= t_f2;
        fwd_csr_data <= t_fc;
    endtask

    task automatic drive_idle();
        issue_valid <= 1'b0;
        fwd_rs1_sel <= 1'b0;
        fwd_rs2_sel <= 1'b0;
        fwd_csr_sel <= 1'b0;
    endtask

    task automatic queue_expect();
        expect_t e;
        e.row        = row_cnt;
        e.cyc        = cyc;
        e.pc         = t_pc;
        e.rd         = t_rd[4:0];
        e.csr_rd     = csr_idx_t'(t_crd[1:0]);
        e.flags      = t_flg[7:0];
        e.commit     = t_ec[0];
        e.alu_out    = t_ealu;
        e.csr_out    = t_ecsr;
        e.store_data = t_est;
        e.redirect   = t_erd[0];
        e.target     = t_etgt;
        e.halted     = t_eh[0];
        exp_q.push_back(e);
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        init_inputs();
        cyc        = 0;
        row_cnt    = 0;
        cur_row    = 0;
        trace_done = 1'b0;

        fd = $fopen("verification/exu_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the trace file verification/exu_trace.txt could not be opened");
            abort_run();
        end
        repeat (HEADER_LINES) begin
            code = $fgets(hdr, fd);
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        wait_cnt = 0;
        @(negedge clk);
        while (commit !== 1'b0 || redirect !== 1'b0 || halted !== 1'b0) begin
            if (wait_cnt >= RESET_TIMEOUT) begin
                $display("ERROR: commit, redirect or halted stayed high after reset");
                abort_run();
            end
            @(negedge clk);
            wait_cnt++;
        end

        while (!trace_done) begin
            @(posedge clk);
            cyc++;
            code = $fscanf(fd,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                t_v, t_pc, t_imm, t_rs1, t_rs2, t_csr, t_rd, t_crd, t_alu,
                t_sa, t_sb, t_br, t_tb, t_cop, t_flg, t_fsel, t_f1, t_f2, t_fc,
                t_ec, t_ealu, t_ecsr, t_est, t_erd, t_etgt, t_eh);
            if (code == ROW_FIELDS) begin
                drive_row();
                queue_expect();
                row_cnt++;
            end else if ($feof(fd) != 0) begin
                drive_idle();
                trace_done = 1'b1;
            end else begin
                $display("ERROR: trace row %0d is malformed, read %0d fields", row_cnt, code);
                abort_run();
            end
            if (row_cnt > MAX_ROWS) begin
                $display("ERROR: the trace has more rows than the run allows");
                abort_run();
            end
            @(negedge clk);
            check_due();
        end

        // let the last rows reach the result register
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            if (wait_cnt >= DRAIN_TIMEOUT) begin
                $display("ERROR: expected results were still pending at the end of the run");
                abort_run();
            end
            @(posedge clk);
            cyc++;
            drive_idle();
            @(negedge clk);
            check_due();
            wait_cnt++;
        end

        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: verification/exu_trace.txt
# issue: v pc imm rs1 rs2 csr rd crd alu sa sb br tb cop flg, fwd of the row above: fsel f1 f2 fc
# expect: commit alu_out csr_out store_data redirect target halted; flg = gpr csr m2r mw size uns halt
1 100 0 5 7 0 1 0 0 0 0 0 0 0 80  0 0 0 0  1 c 0 7 0 0 0
1 104 0 5 7 0 2 0 1 0 0 0 0 0 80  0 0 0 0  1 fffffffe 0 7 0 0 0
1 108 0 ffffffff 1 0 3 0 2 0 0 0 0 0 80  0 0 0 0  1 1 0 1 0 0 0
1 10c 0 ffffffff 1 0 4 0 3 0 0 0 0 0 80  0 0 0 0  1 0 0 1 0 0 0
1 110 f f0 0 0 5 0 4 0 1 0 0 0 80  0 0 0 0  1 ff 0 0 0 0 0
1 114 ff0 ff00ff00 0 0 5 0 5 0 1 0 0 0 80  0 0 0 0  1 f00 0 0 0 0 0
1 118 0 aaaa5555 ffff0000 0 6 0 6 0 0 0 0 0 80  0 0 0 0  1 55555555 0 ffff0000 0 0 0
1 11c 1f 1 0 0 7 0 7 0 1 0 0 0 80  0 0 0 0  1 80000000 0 0 0 0 0
1 120 0 80000000 4 0 8 0 8 0 0 0 0 0 80  0 0 0 0  1 8000000 0 4 0 0 0
1 124 4 80000000 0 0 9 0 9 0 1 0 0 0 80  0 0 0 0  1 f8000000 0 0 0 0 0
1 128 12345000 0 0 0 a 0 a 0 1 0 0 0 80  0 0 0 0  1 12345000 0 0 0 0 0
1 12c 1000 0 0 0 b 0 0 1 1 0 0 0 80  0 0 0 0  1 112c 0 0 0 0 0
1 130 0 3 21 0 c 0 7 0 0 0 0 0 80  0 0 0 0  1 6 0 21 0 0 0
1 134 0 10 20 0 d 0 0 0 0 0 0 0 80  0 0 0 0  1 300 0 200 0 0 0
1 138 8 1000 dead 0 0 0 0 0 1 0 0 0 1c  3 100 200 0  1 1008 0 cafe 0 0 0
1 13c 0 3 0 11 e 0 a 0 3 0 0 2 c0  2 ffff cafe 0  1 88 8b 0 0 0 0
1 140 0 800 0 200 f 1 a 0 3 0 0 1 c0  4 0 0 88  1 200 800 0 0 0 0
1 144 0 0 0 800 0 2 0 0 0 1 2 3 40  0 0 0 0  1 0 144 0 1 800 0
1 148 0 1 2 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 200 10 5 5 0 0 0 1 0 0 2 0 0 0  0 0 0 0  1 0 0 5 1 210 0
1 204 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 210 20 5 5 0 0 0 1 0 0 3 0 0 0  0 0 0 0  1 0 0 5 0 0 0
1 214 fffffff0 3 5 0 0 0 1 0 0 3 0 0 0  0 0 0 0  1 fffffffe 0 5 1 204 0
1 218 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 204 8 fffffffe 1 0 0 0 1 0 0 5 0 0 0  0 0 0 0  1 fffffffd 0 1 1 20c 0
1 208 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 20c 40 fffffffe 1 0 0 0 3 0 0 5 0 0 0  0 0 0 0  1 0 0 1 0 0 0
1 210 40 fffffffe 1 0 0 0 1 0 0 4 0 0 0  0 0 0 0  1 fffffffd 0 1 0 0 0
1 214 100 fffffffe 1 0 0 0 3 0 0 4 0 0 0  0 0 0 0  1 0 0 1 1 314 0
1 218 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 314 40 0 0 0 1 0 0 1 2 1 0 0 80  0 0 0 0  1 318 0 0 1 354 0
1 318 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 354 4 1001 0 0 1 0 0 1 2 1 1 0 80  0 0 0 0  1 358 0 0 1 1004 0
1 358 0 0 0 0 1 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 0
1 1004 2 2000 0 0 1f 3 0 0 1 0 0 0 aa  0 0 0 0  1 2002 0 0 0 0 0
1 1008 fffffffc 3000 12345678 0 0 0 0 0 1 0 0 0 14  0 0 0 0  1 2ffc 0 12345678 0 0 0
1 100c 0 0 0 0 0 0 0 0 0 0 0 0 1  0 0 0 0  1 0 0 0 0 0 0
1 1010 40 0 0 0 1 0 0 1 2 1 0 0 80  0 0 0 0  0 0 0 0 0 0 1
1 1014 0 1 1 0 2 0 0 0 0 0 0 0 80  0 0 0 0  0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 0 0 1

// File: filelist.f
src/rv_isa_pkg.sv
src/exu_ctrl_pkg.sv
src/exu_stage_reg.sv
src/exu_operand_mux.sv
src/exu_alu.sv
src/exu_branch.sv
src/exu_control.sv
src/exu_top.sv
verification/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module exu_tb \
    -f filelist.f -Mdir obj_dir -o exu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/exu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
